//--- rtl/lsu_pkg.sv
// shared widths, types and constants for the load/store unit, compiled ahead of all LSU modules
package lsu_pkg;

  // data and address width of the core
  localparam int unsigned XLEN = 32;

  typedef logic [XLEN-1:0] word_t;

  // architectural register index
  localparam int unsigned REG_IDX_W = 5;

  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // I-type and S-type immediates carry 12 significant bits
  localparam int unsigned IMM_W = 12;

  // one select bit per byte lane of the data bus
  localparam int unsigned SEL_W = XLEN / 8;

  typedef logic [SEL_W-1:0] sel_t;

  // all instructions are 32 bits wide, no compressed set
  localparam int unsigned INST_BYTES = 4;

  // width of a single memory access
  typedef enum logic [1:0]
  {
    MEM_BYTE = 2'd0,
    MEM_HALF = 2'd1,
    MEM_WORD = 2'd2
  } mem_size_e;

endpackage

//--- rtl/lsu_op_capture.sv
// dispatch side of the LSU: registers one memory instruction, decodes it and holds busy
`timescale 1ns/1ns

module lsu_op_capture
(
  input  logic               clk,
  input  logic               rst,

  input  logic               dpu_vld_i,
  input  lsu_pkg::word_t     dpu_pc_i,
  input  lsu_pkg::word_t     dpu_rs1_data_i,
  input  lsu_pkg::word_t     dpu_rs2_data_i,
  input  lsu_pkg::word_t     dpu_imm_i,
  input  lsu_pkg::reg_idx_t  dpu_rd_i,
  input  logic               dpu_lb_i,
  input  logic               dpu_lh_i,
  input  logic               dpu_lw_i,
  input  logic               dpu_lbu_i,
  input  logic               dpu_lhu_i,
  input  logic               dpu_sb_i,
  input  logic               dpu_sh_i,
  input  logic               dpu_sw_i,

  input  logic               retired_i,

  output logic               busy_o,
  output logic               issue_o,
  output logic               fault_o,
  output lsu_pkg::word_t     pc_o,
  output lsu_pkg::word_t     rs1_data_o,
  output lsu_pkg::word_t     rs2_data_o,
  output lsu_pkg::word_t     imm_o,
  output lsu_pkg::reg_idx_t  rd_o,
  output lsu_pkg::mem_size_e size_o,
  output logic               unsigned_o,
  output logic               store_o
);

  import lsu_pkg::*;

  logic       accept;
  logic [7:0] op_flags;
  mem_size_e  size_d;
  logic       valid_q;
  logic       fresh_q;
  logic       no_op_q;

  assign op_flags = {dpu_sw_i, dpu_sh_i, dpu_sb_i, dpu_lhu_i,
                     dpu_lbu_i, dpu_lw_i, dpu_lh_i, dpu_lb_i};

  // a retiring instruction frees the unit in the same cycle
  assign busy_o = valid_q & ~retired_i;
  assign accept = dpu_vld_i & ~busy_o;

  always_comb
  begin
    size_d = MEM_WORD;
    if (dpu_lb_i | dpu_lbu_i | dpu_sb_i)
      size_d = MEM_BYTE;
    else if (dpu_lh_i | dpu_lhu_i | dpu_sh_i)
      size_d = MEM_HALF;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      valid_q <= 1'b0;
      fresh_q <= 1'b0;
    end
    else
    begin
      fresh_q <= accept;
      if (accept)
        valid_q <= 1'b1;
      else if (retired_i)
        valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      pc_o       <= dpu_pc_i;
      rs1_data_o <= dpu_rs1_data_i;
      rs2_data_o <= dpu_rs2_data_i;
      imm_o      <= dpu_imm_i;
      rd_o       <= dpu_rd_i;
      size_o     <= size_d;
      unsigned_o <= dpu_lbu_i | dpu_lhu_i;
      store_o    <= dpu_sb_i | dpu_sh_i | dpu_sw_i;
      no_op_q    <= ~|op_flags;
    end
  end

  // the bus is only touched for a known op at an aligned PC
  assign issue_o = fresh_q & ~no_op_q & (pc_o[1:0] == 2'b00);
  assign fault_o = fresh_q & ~issue_o;

  a_one_op_flag: assert property (@(posedge clk) disable iff (rst)
    accept |-> $onehot0(op_flags));

endmodule

//--- rtl/lsu_addr_align.sv
// forms the effective address and lines up the byte-lane select and store data for the bus
`timescale 1ns/1ns

module lsu_addr_align
(
  input  lsu_pkg::word_t     rs1_data_i,
  input  lsu_pkg::word_t     rs2_data_i,
  input  lsu_pkg::word_t     imm_i,
  input  lsu_pkg::mem_size_e size_i,

  output lsu_pkg::word_t     adr_o,
  output lsu_pkg::word_t     wdata_o,
  output lsu_pkg::sel_t      sel_o,
  output logic [1:0]         offset_o
);

  import lsu_pkg::*;

  word_t      imm_ext;
  word_t      eff_adr;
  logic [1:0] offset;

  // only the low immediate bits are significant and bit 11 is the sign
  assign imm_ext = {{(XLEN-IMM_W){imm_i[IMM_W-1]}}, imm_i[IMM_W-1:0]};
  assign eff_adr = rs1_data_i + imm_ext;
  assign offset  = eff_adr[1:0];

  // the bus is addressed by word and the lanes pick the bytes inside it
  assign adr_o    = {eff_adr[XLEN-1:2], 2'b00};
  assign offset_o = offset;

  always_comb
  begin
    case (size_i)
      MEM_BYTE:
      begin
        sel_o   = sel_t'(1) << offset;
        wdata_o = word_t'(rs2_data_i[7:0]) << {offset, 3'b000};
      end
      MEM_HALF:
      begin
        // a half sits in the low or the high pair of lanes
        sel_o   = offset[1] ? 4'b1100 : 4'b0011;
        wdata_o = word_t'(rs2_data_i[15:0]) << {offset[1], 4'b0000};
      end
      default:
      begin
        sel_o   = '1;
        wdata_o = rs2_data_i;
      end
    endcase
  end

endmodule

//--- rtl/lsu_bus_master.sv
// LSU bus master that issues one strobed access per instruction and waits for the acknowledge
`timescale 1ns/1ns

module lsu_bus_master
(
  input  logic           clk,
  input  logic           rst,

  input  logic           issue_i,
  input  logic           we_i,
  input  lsu_pkg::word_t adr_i,
  input  lsu_pkg::word_t wdata_i,
  input  lsu_pkg::sel_t  sel_i,

  output lsu_pkg::word_t bus_adr_o,
  output lsu_pkg::word_t bus_dat_o,
  output lsu_pkg::sel_t  bus_sel_o,
  output logic           bus_we_o,
  output logic           bus_stb_o,
  output logic           bus_cyc_o,
  input  logic           bus_ack_i,
  input  lsu_pkg::word_t bus_dat_i,

  output logic           rsp_vld_o,
  output lsu_pkg::word_t rsp_data_o
);

  typedef enum logic
  {
    S_IDLE = 1'b0,
    S_WAIT = 1'b1
  } state_e;

  state_e state_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q   <= S_IDLE;
      bus_stb_o <= 1'b0;
      bus_cyc_o <= 1'b0;
      bus_we_o  <= 1'b0;
    end
    else
    begin
      // the strobe marks only the first cycle of the access
      bus_stb_o <= 1'b0;
      case (state_q)
        S_IDLE:
        begin
          if (issue_i)
          begin
            bus_stb_o <= 1'b1;
            bus_cyc_o <= 1'b1;
            bus_we_o  <= we_i;
            state_q   <= S_WAIT;
          end
        end
        default:
        begin
          if (bus_ack_i)
          begin
            bus_cyc_o <= 1'b0;
            bus_we_o  <= 1'b0;
            state_q   <= S_IDLE;
          end
        end
      endcase
    end
  end

  // address, data and lanes stay put for the whole cycle
  always_ff @(posedge clk)
  begin
    if (issue_i && state_q == S_IDLE)
    begin
      bus_adr_o <= adr_i;
      bus_dat_o <= wdata_i;
      bus_sel_o <= sel_i;
    end
  end

  // an acknowledge outside an open cycle is ignored
  assign rsp_vld_o  = bus_cyc_o & bus_ack_i;
  assign rsp_data_o = bus_dat_i;

  a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
    issue_i |-> !bus_cyc_o);

endmodule

//--- rtl/lsu_load_retire.sv
// retire side of the LSU: extends load data and registers write-back, next PC and trap
`timescale 1ns/1ns

module lsu_load_retire
(
  input  logic               clk,
  input  logic               rst,

  input  logic               rsp_vld_i,
  input  logic               fault_i,
  input  lsu_pkg::word_t     rsp_data_i,
  input  lsu_pkg::word_t     pc_i,
  input  logic [1:0]         offset_i,
  input  lsu_pkg::mem_size_e size_i,
  input  logic               unsigned_i,
  input  logic               store_i,
  input  lsu_pkg::reg_idx_t  rd_i,

  output logic               retired_o,
  output logic               trap_o,
  output logic               rd_wr_o,
  output lsu_pkg::reg_idx_t  rd_o,
  output lsu_pkg::word_t     rd_data_o,
  output lsu_pkg::word_t     pc_next_o
);

  import lsu_pkg::*;

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;
  word_t       load_val;
  logic        done;
  logic        rd_wr_d;

  assign done    = rsp_vld_i | fault_i;
  assign rd_wr_d = rsp_vld_i & ~store_i;

  // pick the addressed lanes out of the returned word
  assign lane_byte = rsp_data_i[8*offset_i +: 8];
  assign lane_half = rsp_data_i[16*offset_i[1] +: 16];

  always_comb
  begin
    case (size_i)
      MEM_BYTE:
      begin
        if (unsigned_i)
          load_val = {{(XLEN-8){1'b0}}, lane_byte};
        else
          load_val = {{(XLEN-8){lane_byte[7]}}, lane_byte};
      end
      MEM_HALF:
      begin
        if (unsigned_i)
          load_val = {{(XLEN-16){1'b0}}, lane_half};
        else
          load_val = {{(XLEN-16){lane_half[15]}}, lane_half};
      end
      default:
      begin
        load_val = rsp_data_i;
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      retired_o <= 1'b0;
      trap_o    <= 1'b0;
      rd_wr_o   <= 1'b0;
    end
    else
    begin
      retired_o <= done;
      trap_o    <= fault_i;
      rd_wr_o   <= rd_wr_d;
    end
  end

  always_ff @(posedge clk)
  begin
    if (done)
    begin
      rd_o      <= rd_i;
      pc_next_o <= pc_i + word_t'(INST_BYTES);
      // x0 always reads as zero, stores and traps write nothing
      if (rd_wr_d && rd_i != '0)
        rd_data_o <= load_val;
      else
        rd_data_o <= '0;
    end
  end

  a_wr_on_retire: assert property (@(posedge clk) disable iff (rst)
    rd_wr_o |-> retired_o && !trap_o);

endmodule

//--- rtl/lsu_top.sv
// top level of the load/store unit, connecting dispatch, address alignment, bus and retire stages
`timescale 1ns/1ns

module lsu_top
(
  input  logic              clk,
  input  logic              rst,

  input  logic              dpu_vld_i,
  input  lsu_pkg::word_t    dpu_pc_i,
  input  lsu_pkg::word_t    dpu_rs1_data_i,
  input  lsu_pkg::word_t    dpu_rs2_data_i,
  input  lsu_pkg::word_t    dpu_imm_i,
  input  lsu_pkg::reg_idx_t dpu_rd_i,
  input  logic              dpu_lb_i,
  input  logic              dpu_lh_i,
  input  logic              dpu_lw_i,
  input  logic              dpu_lbu_i,
  input  logic              dpu_lhu_i,
  input  logic              dpu_sb_i,
  input  logic              dpu_sh_i,
  input  logic              dpu_sw_i,
  output logic              lsu_busy_o,

  output lsu_pkg::word_t    bus_adr_o,
  output lsu_pkg::word_t    bus_dat_o,
  output lsu_pkg::sel_t     bus_sel_o,
  output logic              bus_we_o,
  output logic              bus_stb_o,
  output logic              bus_cyc_o,
  input  logic              bus_ack_i,
  input  lsu_pkg::word_t    bus_dat_i,

  output logic              lsu_retired_o,
  output logic              lsu_trap_o,
  output logic              lsu_rd_wr_o,
  output lsu_pkg::reg_idx_t lsu_rd_o,
  output lsu_pkg::word_t    lsu_rd_data_o,
  output lsu_pkg::word_t    lsu_pc_next_o
);

  import lsu_pkg::*;

  logic       issue;
  logic       fault;
  word_t      op_pc;
  word_t      op_rs1_data;
  word_t      op_rs2_data;
  word_t      op_imm;
  reg_idx_t   op_rd;
  mem_size_e  op_size;
  logic       op_unsigned;
  logic       op_store;
  word_t      acc_adr;
  word_t      acc_wdata;
  sel_t       acc_sel;
  logic [1:0] acc_offset;
  logic       rsp_vld;
  word_t      rsp_data;

  lsu_op_capture u_capture
  (
    .clk            (clk),
    .rst            (rst),
    .dpu_vld_i      (dpu_vld_i),
    .dpu_pc_i       (dpu_pc_i),
    .dpu_rs1_data_i (dpu_rs1_data_i),
    .dpu_rs2_data_i (dpu_rs2_data_i),
    .dpu_imm_i      (dpu_imm_i),
    .dpu_rd_i       (dpu_rd_i),
    .dpu_lb_i       (dpu_lb_i),
    .dpu_lh_i       (dpu_lh_i),
    .dpu_lw_i       (dpu_lw_i),
    .dpu_lbu_i      (dpu_lbu_i),
    .dpu_lhu_i      (dpu_lhu_i),
    .dpu_sb_i       (dpu_sb_i),
    .dpu_sh_i       (dpu_sh_i),
    .dpu_sw_i       (dpu_sw_i),
    .retired_i      (lsu_retired_o),
    .busy_o         (lsu_busy_o),
    .issue_o        (issue),
    .fault_o        (fault),
    .pc_o           (op_pc),
    .rs1_data_o     (op_rs1_data),
    .rs2_data_o     (op_rs2_data),
    .imm_o          (op_imm),
    .rd_o           (op_rd),
    .size_o         (op_size),
    .unsigned_o     (op_unsigned),
    .store_o        (op_store)
  );

  lsu_addr_align u_align
  (
    .rs1_data_i (op_rs1_data),
    .rs2_data_i (op_rs2_data),
    .imm_i      (op_imm),
    .size_i     (op_size),
    .adr_o      (acc_adr),
    .wdata_o    (acc_wdata),
    .sel_o      (acc_sel),
    .offset_o   (acc_offset)
  );

  lsu_bus_master u_bus
  (
    .clk        (clk),
    .rst        (rst),
    .issue_i    (issue),
    .we_i       (op_store),
    .adr_i      (acc_adr),
    .wdata_i    (acc_wdata),
    .sel_i      (acc_sel),
    .bus_adr_o  (bus_adr_o),
    .bus_dat_o  (bus_dat_o),
    .bus_sel_o  (bus_sel_o),
    .bus_we_o   (bus_we_o),
    .bus_stb_o  (bus_stb_o),
    .bus_cyc_o  (bus_cyc_o),
    .bus_ack_i  (bus_ack_i),
    .bus_dat_i  (bus_dat_i),
    .rsp_vld_o  (rsp_vld),
    .rsp_data_o (rsp_data)
  );

  lsu_load_retire u_retire
  (
    .clk        (clk),
    .rst        (rst),
    .rsp_vld_i  (rsp_vld),
    .fault_i    (fault),
    .rsp_data_i (rsp_data),
    .pc_i       (op_pc),
    .offset_i   (acc_offset),
    .size_i     (op_size),
    .unsigned_i (op_unsigned),
    .store_i    (op_store),
    .rd_i       (op_rd),
    .retired_o  (lsu_retired_o),
    .trap_o     (lsu_trap_o),
    .rd_wr_o    (lsu_rd_wr_o),
    .rd_o       (lsu_rd_o),
    .rd_data_o  (lsu_rd_data_o),
    .pc_next_o  (lsu_pc_next_o)
  );

endmodule

//--- bench/data_mem_model.sv
// memory bus slave for the LSU testbench with byte-lane writes and a random acknowledge delay
`timescale 1ns/1ns

module data_mem_model
#(
  parameter int DEPTH = 64,
  parameter int SEED  = 1
)
(
  input  logic           clk,
  input  logic           rst,
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           we_i,
  input  lsu_pkg::word_t adr_i,
  input  lsu_pkg::word_t dat_i,
  input  lsu_pkg::sel_t  sel_i,
  output logic           ack_o,
  output lsu_pkg::word_t dat_o
);

  import lsu_pkg::*;

  localparam int AW = $clog2(DEPTH);

  word_t         mem [DEPTH];
  int            seed = SEED;
  int            wait_q;
  logic          pending_q;
  logic [AW-1:0] idx;

  // every byte of the fill pattern depends on the full word index
  function automatic word_t fill_word(input int i);
    return {8'(i) ^ 8'hA5, 8'(i), ~8'(i), 8'(i) + 8'h3C};
  endfunction

  assign idx = adr_i[2 +: AW];

  always @(posedge clk)
  begin
    if (rst)
    begin
      ack_o     <= 1'b0;
      pending_q <= 1'b0;
      wait_q    <= 0;
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= fill_word(i);
    end
    else
    begin
      ack_o <= 1'b0;
      if (cyc_i && stb_i)
      begin
        // the master holds address and data until the acknowledge
        pending_q <= 1'b1;
        wait_q    <= 1 + int'($unsigned($random(seed)) % 4);
      end
      else if (pending_q)
      begin
        wait_q <= wait_q - 1;
        if (wait_q == 1)
        begin
          ack_o     <= 1'b1;
          pending_q <= 1'b0;
          dat_o     <= mem[idx];
          if (we_i)
            for (int b = 0; b < SEL_W; b++)
              if (sel_i[b])
                mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
  end

endmodule

//--- bench/lsu_tb.sv
// LSU testbench driving loads, stores and traps against a memory model with assertion checks
`timescale 1ns/1ns

module lsu_tb;

  import lsu_pkg::*;

  localparam int MEM_DEPTH  = 64;
  localparam int MEM_AW     = $clog2(MEM_DEPTH);
  localparam int SEED       = 32;
  localparam int WAIT_LIMIT = 40;

  // each operation code is the position of its flag on the dispatch port
  localparam int K_LB   = 0;
  localparam int K_LH   = 1;
  localparam int K_LW   = 2;
  localparam int K_LBU  = 3;
  localparam int K_LHU  = 4;
  localparam int K_SB   = 5;
  localparam int K_SH   = 6;
  localparam int K_SW   = 7;
  localparam int K_NONE = 8;

  logic     clk, rst, dpu_vld_i, lsu_busy_o;
  word_t    dpu_pc_i, dpu_rs1_data_i, dpu_rs2_data_i, dpu_imm_i;
  reg_idx_t dpu_rd_i, lsu_rd_o;
  logic     dpu_lb_i, dpu_lh_i, dpu_lw_i, dpu_lbu_i, dpu_lhu_i, dpu_sb_i, dpu_sh_i, dpu_sw_i;
  word_t    bus_adr_o, bus_dat_o, bus_dat_i;
  sel_t     bus_sel_o;
  logic     bus_we_o, bus_stb_o, bus_cyc_o, bus_ack_i;
  logic     lsu_retired_o, lsu_trap_o, lsu_rd_wr_o;
  word_t    lsu_rd_data_o, lsu_pc_next_o;

  int          errors, timeouts, seed, in_flight, n_issued, n_acc, n_ret;
  word_t       pc_ctr;
  word_t       shadow [MEM_DEPTH];
  logic        accepting, ref_byte, ref_half, ref_store, ref_unsigned, ref_trap;
  logic [1:0]  ref_off;
  sel_t        ref_sel;
  word_t       ref_eff, ref_repl, ref_dat, ref_word, ref_load;
  logic [7:0]  ref_lane_b;
  logic [15:0] ref_lane_h;
  logic        exp_we, exp_trap, exp_rd_wr;
  word_t       exp_adr, exp_dat, exp_pc_next, exp_rd_data;
  sel_t        exp_sel;
  reg_idx_t    exp_rd;

  lsu_top dut0 (.*);

  data_mem_model #(.DEPTH(MEM_DEPTH), .SEED(SEED)) mem0
  (
    .clk   (clk),
    .rst   (rst),
    .cyc_i (bus_cyc_o),
    .stb_i (bus_stb_o),
    .we_i  (bus_we_o),
    .adr_i (bus_adr_o),
    .dat_i (bus_dat_o),
    .sel_i (bus_sel_o),
    .ack_o (bus_ack_i),
    .dat_o (bus_dat_i)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // same contents as the memory model holds after reset
  function automatic word_t fill_word(input int i);
    return {8'(i) ^ 8'hA5, 8'(i), ~8'(i), 8'(i) + 8'h3C};
  endfunction

  assign accepting = dpu_vld_i && !lsu_busy_o;

  // expected lanes, store data and load result of the instruction on the dispatch port
  always_comb
  begin
    ref_byte     = dpu_lb_i | dpu_lbu_i | dpu_sb_i;
    ref_half     = dpu_lh_i | dpu_lhu_i | dpu_sh_i;
    ref_store    = dpu_sb_i | dpu_sh_i | dpu_sw_i;
    ref_unsigned = dpu_lbu_i | dpu_lhu_i;
    ref_trap     = (dpu_pc_i[1:0] != 2'b00) || !(ref_byte || ref_half || ref_store || dpu_lw_i);
    ref_eff      = dpu_rs1_data_i + {{(XLEN-12){dpu_imm_i[11]}}, dpu_imm_i[11:0]};
    ref_off      = ref_eff[1:0];
    if (ref_byte)
    begin
      ref_sel  = sel_t'(1 << ref_off);
      ref_repl = {4{dpu_rs2_data_i[7:0]}};
    end
    else if (ref_half)
    begin
      ref_sel  = ref_off[1] ? 4'b1100 : 4'b0011;
      ref_repl = {2{dpu_rs2_data_i[15:0]}};
    end
    else
    begin
      ref_sel  = 4'b1111;
      ref_repl = dpu_rs2_data_i;
    end
    for (int b = 0; b < SEL_W; b++)
      ref_dat[8*b +: 8] = ref_sel[b] ? ref_repl[8*b +: 8] : 8'h00;
    ref_word   = shadow[ref_eff[2 +: MEM_AW]];
    ref_lane_b = ref_word[8*ref_off +: 8];
    ref_lane_h = ref_off[1] ? ref_word[31:16] : ref_word[15:0];
    if (ref_byte)
      ref_load = {{24{ref_lane_b[7] & !ref_unsigned}}, ref_lane_b};
    else if (ref_half)
      ref_load = {{16{ref_lane_h[15] & !ref_unsigned}}, ref_lane_h};
    else
      ref_load = ref_word;
    if (dpu_rd_i == '0)
      ref_load = '0;
  end

  always @(posedge clk)
  begin
    if (rst)
    begin
      in_flight <= 0;
      n_acc     <= 0;
      n_ret     <= 0;
      for (int i = 0; i < MEM_DEPTH; i++)
        shadow[i] <= fill_word(i);
    end
    else
    begin
      in_flight <= in_flight + int'(accepting) - int'(lsu_retired_o);
      n_ret     <= n_ret + int'(lsu_retired_o);
      if (accepting)
      begin
        n_acc       <= n_acc + 1;
        exp_adr     <= {ref_eff[XLEN-1:2], 2'b00};
        exp_sel     <= ref_sel;
        exp_dat     <= ref_dat;
        exp_we      <= ref_store;
        exp_trap    <= ref_trap;
        exp_rd_wr   <= !ref_store && !ref_trap;
        exp_rd      <= dpu_rd_i;
        exp_rd_data <= ref_load;
        exp_pc_next <= dpu_pc_i + 32'd4;
        if (ref_store && !ref_trap)
          for (int b = 0; b < SEL_W; b++)
            if (ref_sel[b])
              shadow[ref_eff[2 +: MEM_AW]][8*b +: 8] <= ref_dat[8*b +: 8];
      end
    end
  end

  task automatic report_mismatch(input string what);
    errors++;
    $display("mismatch at %0t ns: %s", $time, what);
  endtask

  a_reset_low: assert property (@(posedge clk) rst |=> !lsu_busy_o && !bus_stb_o && !bus_cyc_o
    && !bus_we_o && !lsu_retired_o && !lsu_trap_o && !lsu_rd_wr_o)
    else report_mismatch("an output is high after reset");

  a_bus_req: assert property (@(posedge clk) disable iff (rst) bus_stb_o |-> bus_cyc_o
    && bus_adr_o == exp_adr && bus_sel_o == exp_sel && bus_we_o == exp_we)
    else report_mismatch("bus address, lanes or direction");

  a_store_data: assert property (@(posedge clk) disable iff (rst)
    bus_stb_o && bus_we_o |-> bus_dat_o == exp_dat)
    else report_mismatch("store data on the bus");

  a_stb_pulse: assert property (@(posedge clk) disable iff (rst) bus_stb_o |=> !bus_stb_o)
    else report_mismatch("strobe longer than one cycle");

  a_cyc_hold: assert property (@(posedge clk) disable iff (rst)
    bus_cyc_o && !bus_ack_i |=> bus_cyc_o)
    else report_mismatch("cyc dropped before the acknowledge");

  a_cyc_end: assert property (@(posedge clk) disable iff (rst)
    bus_cyc_o && bus_ack_i |=> !bus_cyc_o)
    else report_mismatch("cyc still high after the acknowledge");

  a_legal_stb: assert property (@(posedge clk) disable iff (rst)
    accepting && !ref_trap |-> ##2 bus_stb_o)
    else report_mismatch("no strobe in the cycle after E1");

  a_fault_retire: assert property (@(posedge clk) disable iff (rst)
    accepting && ref_trap |-> ##1 !bus_stb_o ##1 (!bus_stb_o && lsu_retired_o && lsu_trap_o))
    else report_mismatch("trapped instruction timing or strobe");

  a_retire_vals: assert property (@(posedge clk) disable iff (rst) lsu_retired_o |->
    lsu_trap_o == exp_trap && lsu_rd_wr_o == exp_rd_wr && lsu_pc_next_o == exp_pc_next)
    else report_mismatch("trap, rd_wr or pc_next at retirement");

  a_load_data: assert property (@(posedge clk) disable iff (rst)
    lsu_rd_wr_o |-> lsu_rd_o == exp_rd && lsu_rd_data_o == exp_rd_data)
    else report_mismatch("load write-back register or data");

  a_accept_free: assert property (@(posedge clk) disable iff (rst)
    accepting |-> in_flight == 0 || lsu_retired_o)
    else report_mismatch("instruction accepted while one is in flight");

  a_busy_held: assert property (@(posedge clk) disable iff (rst)
    (in_flight != 0 && !lsu_retired_o) == lsu_busy_o)
    else report_mismatch("busy does not match the instruction in flight");

  task automatic finish_run();
    $display("%0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic wait_not_busy();
    int n;
    n = 0;
    while (lsu_busy_o && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (lsu_busy_o)
    begin
      $display("timeout: the LSU stayed busy for %0d cycles", WAIT_LIMIT);
      timeouts++;
      finish_run();
    end
  endtask

  task automatic wait_retired();
    int n;
    n = 0;
    while (!lsu_retired_o && n < WAIT_LIMIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!lsu_retired_o)
    begin
      $display("timeout: no retirement within %0d cycles", WAIT_LIMIT);
      timeouts++;
      finish_run();
    end
  endtask

  // presents one instruction and returns on the falling edge after it was accepted
  task automatic issue_op(input int kind, input word_t pc, input word_t rs1, input word_t rs2,
                          input word_t imm, input reg_idx_t rd, input bit hold);
    {dpu_sw_i, dpu_sh_i, dpu_sb_i, dpu_lhu_i, dpu_lbu_i, dpu_lw_i, dpu_lh_i, dpu_lb_i} =
      (kind < 8) ? 8'(1 << kind) : 8'h00;
    dpu_pc_i       = pc;
    dpu_rs1_data_i = rs1;
    dpu_rs2_data_i = rs2;
    dpu_imm_i      = imm;
    dpu_rd_i       = rd;
    dpu_vld_i      = 1'b1;
    n_issued++;
    wait_not_busy();
    @(negedge clk);
    if (!hold)
      dpu_vld_i = 1'b0;
  endtask

  task automatic do_op(input int kind, input word_t rs1, input word_t rs2, input word_t imm,
                       input reg_idx_t rd);
    issue_op(kind, pc_ctr, rs1, rs2, imm, rd, 1'b0);
    pc_ctr += 32'd4;
    wait_retired();
  endtask

  initial
  begin
    int kind;
    errors   = 0;
    timeouts = 0;
    n_issued = 0;
    seed     = SEED;
    pc_ctr   = 32'h0000_1000;
    rst      = 1'b1;
    clear_inputs();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    // word store reached through a negative immediate and read back
    do_op(K_SW, 32'h0000_0120, 32'h1234_5678, 32'h0000_0FF0, '0);
    do_op(K_LW, 32'h0000_0100, '0, 32'h0000_0010, 5'd5);

    for (int off = 0; off < 4; off++)
    begin
      do_op(K_SB, 32'h0000_0140, 32'h0000_01A0 + 32'(off), 32'(off), '0);
      do_op(K_SH, 32'h0000_0144, 32'h0005_B0C0 + 32'(off), 32'(off), '0);
    end
    do_op(K_LW, 32'h0000_0140, '0, '0, 5'd6);
    do_op(K_LW, 32'h0000_0144, '0, '0, 5'd7);

    // bytes and halves with mixed sign bits for the extension rules
    do_op(K_SW, 32'h0000_0180, 32'h80FF_7F81, '0, '0);
    do_op(K_SW, 32'h0000_0184, 32'hF1E2_D3C4, '0, '0);
    for (int w = 0; w < 2; w++)
      for (int off = 0; off < 4; off++)
        for (int k = 0; k < 4; k++)
          do_op(k < 2 ? k : k + 1, 32'h0000_0180 + 32'(4 * w), '0, 32'(off), 5'(1 + off));
    do_op(K_LW, 32'h0000_0180, '0, '0, '0);

    // a trapped store must leave memory unchanged
    issue_op(K_SW, pc_ctr + 32'd2, 32'h0000_0180, 32'hDEAD_BEEF, '0, '0, 1'b0);
    wait_retired();
    issue_op(K_NONE, pc_ctr, 32'h0000_0180, '0, '0, 5'd8, 1'b0);
    wait_retired();
    pc_ctr += 32'd4;
    do_op(K_LW, 32'h0000_0180, '0, '0, 5'd9);

    // back-to-back random instructions with valid held high
    for (int i = 0; i < 12; i++)
    begin
      kind = int'($unsigned($random(seed)) % 9);
      issue_op(kind, pc_ctr, $random(seed), $random(seed), $random(seed), 5'($random(seed)), 1'b1);
      pc_ctr += 32'd4;
    end
    dpu_vld_i = 1'b0;
    wait_retired();
    @(negedge clk);

    a_counts: assert (n_acc == n_issued && n_ret == n_issued)
      else report_mismatch($sformatf("%0d issued, %0d accepted, %0d retired",
                                     n_issued, n_acc, n_ret));
    finish_run();
  end

  task automatic clear_inputs();
    {dpu_sw_i, dpu_sh_i, dpu_sb_i, dpu_lhu_i, dpu_lbu_i, dpu_lw_i, dpu_lh_i, dpu_lb_i} = 8'h00;
    dpu_vld_i      = 1'b0;
    dpu_pc_i       = '0;
    dpu_rs1_data_i = '0;
    dpu_rs2_data_i = '0;
    dpu_imm_i      = '0;
    dpu_rd_i       = '0;
  endtask

endmodule

//--- src.f
rtl/lsu_pkg.sv
rtl/lsu_op_capture.sv
rtl/lsu_addr_align.sv
rtl/lsu_bus_master.sv
rtl/lsu_load_retire.sv
rtl/lsu_top.sv
bench/data_mem_model.sv
bench/lsu_tb.sv
